/* Makefile */
VERILATOR ?= verilator
FLAGS ?= --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
TOP ?= tb_top
FILELIST ?= build.f
OBJ_DIR ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
common/lsu_pkg.sv
source/basic_cache.sv
load_store/load_store.sv
source/fetch_unit.sv
source/bus_arbiter.sv
source/mem_bram.sv
source/mem_subsystem_top.sv
tests/mem_subsystem_assert.sv
tests/tb_top.sv

/* common/lsu_pkg.sv */
package lsu_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    localparam int xlen = 64;
    localparam int ilen = 32;
    localparam int addr_size = 16;

    // byte address without the 3 offset bits.
    localparam int aligned_addr_size = 13;

    // --------------------------------------------------
    // cache geometry
    // --------------------------------------------------
    localparam int cache_index_bits = 4;
    localparam int cache_entries = 1 << cache_index_bits;

    // --------------------------------------------------
    // memory and bus
    // --------------------------------------------------
    // words backed by storage, anything above answers slverr.
    localparam int mem_words = 4096;
    localparam int mem_index_bits = $clog2(mem_words);

    localparam logic [1:0] resp_okay = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // arbiter grant encodings.
    localparam logic peer_lsu = 1'b0;
    localparam logic peer_fetch = 1'b1;

endpackage

/* load_store/load_store.sv */
`timescale 1ns/1ps

module load_store (
    input  logic clk,
    input  logic rst,
    input  logic prev_stalled,
    output logic stall_next,
    input  logic [lsu_pkg::aligned_addr_size-1:0] addr,
    output logic access_fault,
    input  logic do_load,
    output logic [lsu_pkg::xlen-1:0] load_data,
    input  logic do_store,
    input  logic [lsu_pkg::xlen-1:0] store_data,
    input  logic [lsu_pkg::xlen/8-1:0] store_mask,
    output logic arvalid,
    input  logic arready,
    output logic [lsu_pkg::addr_size-1:0] araddr,
    input  logic rvalid,
    output logic rready,
    input  logic [lsu_pkg::xlen-1:0] rdata,
    input  logic [1:0] rresp,
    output logic awvalid,
    input  logic awready,
    output logic [lsu_pkg::addr_size-1:0] awaddr,
    output logic wvalid,
    input  logic wready,
    output logic [lsu_pkg::xlen-1:0] wdata,
    output logic [lsu_pkg::xlen/8-1:0] wstrb,
    input  logic bvalid,
    output logic bready,
    input  logic [1:0] bresp
);

    typedef enum logic [2:0] {
        s_idle,
        s_load_check,
        s_load_addr,
        s_load_data,
        s_store_check,
        s_store_wait
    } state_t;

    state_t state;
    logic [lsu_pkg::aligned_addr_size-1:0] addr_buf;
    logic [lsu_pkg::xlen-1:0] store_data_buf;
    logic [lsu_pkg::xlen/8-1:0] store_mask_buf;
    logic start_load;
    logic start_store;
    logic accept;
    logic done;
    logic cache_we;
    logic cache_hit;
    logic [lsu_pkg::aligned_addr_size-1:0] cache_raddr;
    logic [lsu_pkg::xlen-1:0] cache_wdata;
    logic [lsu_pkg::xlen-1:0] cache_rdata;

    // --------------------------------------------------
    // request handshake
    // --------------------------------------------------
    assign start_load = !prev_stalled && do_load && !do_store;
    assign start_store = !prev_stalled && do_store && !do_load;

    // next request may start in the cycle the current one ends.
    assign accept = (state == s_idle || done) && (start_load || start_store);

    always_comb begin
        case (state)
            s_load_check: done = cache_hit;
            s_load_data: done = rvalid;
            s_store_wait: done = bvalid;
            default: done = 1'b0;
        endcase
    end

    assign stall_next = !done;
    assign load_data = state == s_load_data ? rdata : cache_rdata;
    assign access_fault = (state == s_load_data && rresp != lsu_pkg::resp_okay) ||
                          (state == s_store_wait && bresp != lsu_pkg::resp_okay);

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_buf <= addr;
            store_data_buf <= store_data;
            store_mask_buf <= store_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
        end else if (accept) begin
            state <= start_load ? s_load_check : s_store_check;
        end else if (done) begin
            state <= s_idle;
        end else begin
            case (state)
                s_load_check, s_load_addr: state <= arready ? s_load_data : s_load_addr;
                s_store_check: state <= s_store_wait;
                default: state <= state;
            endcase
        end
    end

    // --------------------------------------------------
    // data cache
    // --------------------------------------------------
    // lookup for a new request uses the incoming address.
    assign cache_raddr = accept ? addr : addr_buf;

    always_comb begin
        cache_we = 1'b0;
        cache_wdata = rdata;
        if (state == s_load_data) begin
            cache_we = rvalid && rresp == lsu_pkg::resp_okay;
        end else if (state == s_store_check) begin
            // no allocate unless the store covers the whole word.
            cache_we = cache_hit || &store_mask_buf;
            for (int i = 0; i < lsu_pkg::xlen / 8; i++) begin
                cache_wdata[i*8 +: 8] = store_mask_buf[i] ? store_data_buf[i*8 +: 8]
                                                          : cache_rdata[i*8 +: 8];
            end
        end
    end

    basic_cache #(
        .payload_t(logic [lsu_pkg::xlen-1:0]),
        .addr_bits(lsu_pkg::aligned_addr_size)
    ) u_dcache (
        .clk(clk),
        .rst(rst),
        .write_enable(cache_we),
        .waddr(addr_buf),
        .wdata(cache_wdata),
        .raddr(cache_raddr),
        .rdata(cache_rdata),
        .lookup_valid(cache_hit)
    );

    // --------------------------------------------------
    // bus side
    // --------------------------------------------------
    assign arvalid = (state == s_load_check && !cache_hit) || state == s_load_addr;
    assign araddr = {addr_buf, 3'b000};
    assign rready = state == s_load_data;
    assign awaddr = {addr_buf, 3'b000};
    assign wdata = store_data_buf;
    assign wstrb = store_mask_buf;
    assign bready = state == s_store_wait;

    // write-through, aw and w go out the cycle after accept.
    always_ff @(posedge clk) begin
        if (rst) begin
            awvalid <= 1'b0;
            wvalid <= 1'b0;
        end else if (accept && start_store) begin
            awvalid <= 1'b1;
            wvalid <= 1'b1;
        end else begin
            if (awready) begin
                awvalid <= 1'b0;
            end
            if (wready) begin
                wvalid <= 1'b0;
            end
        end
    end

endmodule

/* source/basic_cache.sv */
`timescale 1ns/1ps

module basic_cache #(
    parameter type payload_t = logic [63:0],
    parameter int addr_bits = lsu_pkg::aligned_addr_size
) (
    input  logic clk,
    input  logic rst,
    input  logic write_enable,
    input  logic [addr_bits-1:0] waddr,
    input  payload_t wdata,
    input  logic [addr_bits-1:0] raddr,
    output payload_t rdata,
    output logic lookup_valid
);

    logic [lsu_pkg::cache_entries-1:0] valid_bits;
    logic [addr_bits-1:lsu_pkg::cache_index_bits] tags [lsu_pkg::cache_entries];
    payload_t data [lsu_pkg::cache_entries];
    logic [lsu_pkg::cache_index_bits-1:0] widx;
    logic [lsu_pkg::cache_index_bits-1:0] ridx;
    logic bypass;

    assign widx = waddr[lsu_pkg::cache_index_bits-1:0];
    assign ridx = raddr[lsu_pkg::cache_index_bits-1:0];
    assign bypass = write_enable && waddr == raddr;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
        end else if (write_enable) begin
            valid_bits[widx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write_enable) begin
            tags[widx] <= waddr[addr_bits-1:lsu_pkg::cache_index_bits];
            data[widx] <= wdata;
        end
    end

    // registered read, same-address write is forwarded.
    always_ff @(posedge clk) begin
        rdata <= bypass ? wdata : data[ridx];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lookup_valid <= 1'b0;
        end else begin
            lookup_valid <= bypass || (valid_bits[ridx] &&
                tags[ridx] == raddr[addr_bits-1:lsu_pkg::cache_index_bits]);
        end
    end

endmodule

/* source/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
    input  logic clk,
    input  logic rst,
    // load/store peer
    input  logic lsu_arvalid,
    output logic lsu_arready,
    input  logic [lsu_pkg::addr_size-1:0] lsu_araddr,
    output logic lsu_rvalid,
    input  logic lsu_rready,
    output logic [lsu_pkg::xlen-1:0] lsu_rdata,
    output logic [1:0] lsu_rresp,
    input  logic lsu_awvalid,
    output logic lsu_awready,
    input  logic [lsu_pkg::addr_size-1:0] lsu_awaddr,
    input  logic lsu_wvalid,
    output logic lsu_wready,
    input  logic [lsu_pkg::xlen-1:0] lsu_wdata,
    input  logic [lsu_pkg::xlen/8-1:0] lsu_wstrb,
    output logic lsu_bvalid,
    input  logic lsu_bready,
    output logic [1:0] lsu_bresp,
    // fetch peer, read only
    input  logic fetch_arvalid,
    output logic fetch_arready,
    input  logic [lsu_pkg::addr_size-1:0] fetch_araddr,
    output logic fetch_rvalid,
    input  logic fetch_rready,
    output logic [lsu_pkg::xlen-1:0] fetch_rdata,
    output logic [1:0] fetch_rresp,
    // memory
    output logic mem_arvalid,
    input  logic mem_arready,
    output logic [lsu_pkg::addr_size-1:0] mem_araddr,
    input  logic mem_rvalid,
    output logic mem_rready,
    input  logic [lsu_pkg::xlen-1:0] mem_rdata,
    input  logic [1:0] mem_rresp,
    output logic mem_awvalid,
    input  logic mem_awready,
    output logic [lsu_pkg::addr_size-1:0] mem_awaddr,
    output logic mem_wvalid,
    input  logic mem_wready,
    output logic [lsu_pkg::xlen-1:0] mem_wdata,
    output logic [lsu_pkg::xlen/8-1:0] mem_wstrb,
    input  logic mem_bvalid,
    output logic mem_bready,
    input  logic [1:0] mem_bresp
);

    logic busy;
    logic owner;
    logic sel;
    logic lsu_req;
    logic lsu_sel;
    logic fetch_sel;
    logic last_beat;

    assign lsu_req = lsu_arvalid || lsu_awvalid || lsu_wvalid;
    assign last_beat = (mem_rvalid && mem_rready) || (mem_bvalid && mem_bready);

    // fixed priority while idle, lsu wins a tie.
    assign sel = busy ? owner : (lsu_req ? lsu_pkg::peer_lsu : lsu_pkg::peer_fetch);
    assign lsu_sel = sel == lsu_pkg::peer_lsu;
    assign fetch_sel = sel == lsu_pkg::peer_fetch;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            owner <= lsu_pkg::peer_lsu;
        end else if (!busy && (lsu_req || fetch_arvalid)) begin
            busy <= 1'b1;
            owner <= sel;
        end else if (busy && last_beat) begin
            busy <= 1'b0;
        end
    end

    // --------------------------------------------------
    // routing toward memory
    // --------------------------------------------------
    assign mem_arvalid = lsu_sel ? lsu_arvalid : fetch_arvalid;
    assign mem_araddr = lsu_sel ? lsu_araddr : fetch_araddr;
    assign mem_rready = lsu_sel ? lsu_rready : fetch_rready;
    assign mem_awvalid = lsu_sel && lsu_awvalid;
    assign mem_awaddr = lsu_awaddr;
    assign mem_wvalid = lsu_sel && lsu_wvalid;
    assign mem_wdata = lsu_wdata;
    assign mem_wstrb = lsu_wstrb;
    assign mem_bready = lsu_sel && lsu_bready;

    // --------------------------------------------------
    // routing back to the peers
    // --------------------------------------------------
    assign lsu_arready = lsu_sel && mem_arready;
    assign lsu_rvalid = lsu_sel && mem_rvalid;
    assign lsu_rdata = mem_rdata;
    assign lsu_rresp = mem_rresp;
    assign lsu_awready = lsu_sel && mem_awready;
    assign lsu_wready = lsu_sel && mem_wready;
    assign lsu_bvalid = lsu_sel && mem_bvalid;
    assign lsu_bresp = mem_bresp;
    assign fetch_arready = fetch_sel && mem_arready;
    assign fetch_rvalid = fetch_sel && mem_rvalid;
    assign fetch_rdata = mem_rdata;
    assign fetch_rresp = mem_rresp;

endmodule

/* source/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic clk,
    input  logic rst,
    input  logic fetch_req,
    input  logic [lsu_pkg::addr_size-3:0] fetch_addr,
    output logic fetch_done,
    output logic [lsu_pkg::ilen-1:0] fetch_instr,
    output logic fetch_fault,
    output logic arvalid,
    input  logic arready,
    output logic [lsu_pkg::addr_size-1:0] araddr,
    input  logic rvalid,
    output logic rready,
    input  logic [lsu_pkg::xlen-1:0] rdata,
    input  logic [1:0] rresp
);

    typedef enum logic [1:0] {f_idle, f_check, f_addr, f_data} state_t;

    state_t state;
    logic [lsu_pkg::addr_size-3:0] addr_buf;
    logic [lsu_pkg::ilen-1:0] bus_half;
    logic [lsu_pkg::ilen-1:0] cache_rdata;
    logic cache_hit;
    logic cache_we;

    always_ff @(posedge clk) begin
        if (fetch_req) begin
            addr_buf <= fetch_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= f_idle;
        end else if (fetch_req) begin
            state <= f_check;
        end else begin
            case (state)
                f_check: state <= cache_hit ? f_idle : (arready ? f_data : f_addr);
                f_addr: state <= arready ? f_data : f_addr;
                f_data: state <= rvalid ? f_idle : f_data;
                default: state <= f_idle;
            endcase
        end
    end

    // low address bit picks the half of the 64-bit word.
    assign bus_half = addr_buf[0] ? rdata[63:32] : rdata[31:0];

    assign fetch_done = (state == f_check && cache_hit) || (state == f_data && rvalid);
    assign fetch_instr = state == f_data ? bus_half : cache_rdata;
    assign fetch_fault = state == f_data && rresp != lsu_pkg::resp_okay;
    assign cache_we = state == f_data && rvalid && rresp == lsu_pkg::resp_okay;

    assign arvalid = (state == f_check && !cache_hit) || state == f_addr;
    assign araddr = {addr_buf[lsu_pkg::addr_size-3:1], 3'b000};
    assign rready = state == f_data;

    basic_cache #(
        .payload_t(logic [lsu_pkg::ilen-1:0]),
        .addr_bits(lsu_pkg::addr_size - 2)
    ) u_icache (
        .clk(clk),
        .rst(rst),
        .write_enable(cache_we),
        .waddr(addr_buf),
        .wdata(bus_half),
        .raddr(fetch_req ? fetch_addr : addr_buf),
        .rdata(cache_rdata),
        .lookup_valid(cache_hit)
    );

endmodule

/* source/mem_bram.sv */
`timescale 1ns/1ps

module mem_bram (
    input  logic clk,
    input  logic rst,
    input  logic arvalid,
    output logic arready,
    input  logic [lsu_pkg::addr_size-1:0] araddr,
    output logic rvalid,
    input  logic rready,
    output logic [lsu_pkg::xlen-1:0] rdata,
    output logic [1:0] rresp,
    input  logic awvalid,
    output logic awready,
    input  logic [lsu_pkg::addr_size-1:0] awaddr,
    input  logic wvalid,
    output logic wready,
    input  logic [lsu_pkg::xlen-1:0] wdata,
    input  logic [lsu_pkg::xlen/8-1:0] wstrb,
    output logic bvalid,
    input  logic bready,
    output logic [1:0] bresp
);

    typedef enum logic [1:0] {m_idle, m_read_resp, m_write_resp} state_t;

    state_t state;
    logic [lsu_pkg::xlen-1:0] mem [lsu_pkg::mem_words] = '{default: '0};
    logic [lsu_pkg::aligned_addr_size-1:0] rword;
    logic [lsu_pkg::aligned_addr_size-1:0] wword;
    logic ar_beat;
    logic aw_beat;

    assign rword = araddr[lsu_pkg::addr_size-1:3];
    assign wword = awaddr[lsu_pkg::addr_size-1:3];

    // aw and w are taken together.
    assign arready = state == m_idle;
    assign awready = state == m_idle && awvalid && wvalid && !arvalid;
    assign wready = awready;
    assign rvalid = state == m_read_resp;
    assign bvalid = state == m_write_resp;
    assign ar_beat = arvalid && arready;
    assign aw_beat = awvalid && awready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= m_idle;
        end else begin
            case (state)
                m_idle: state <= ar_beat ? m_read_resp : (aw_beat ? m_write_resp : m_idle);
                m_read_resp: state <= rready ? m_idle : m_read_resp;
                m_write_resp: state <= bready ? m_idle : m_write_resp;
                default: state <= m_idle;
            endcase
        end
    end

    // out of range touches no storage.
    always_ff @(posedge clk) begin
        if (ar_beat) begin
            rresp <= rword < lsu_pkg::mem_words ? lsu_pkg::resp_okay : lsu_pkg::resp_slverr;
            rdata <= rword < lsu_pkg::mem_words ? mem[rword[lsu_pkg::mem_index_bits-1:0]] : '0;
        end
        if (aw_beat) begin
            bresp <= wword < lsu_pkg::mem_words ? lsu_pkg::resp_okay : lsu_pkg::resp_slverr;
            for (int i = 0; i < lsu_pkg::xlen / 8; i++) begin
                if (wword < lsu_pkg::mem_words && wstrb[i]) begin
                    mem[wword[lsu_pkg::mem_index_bits-1:0]][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

endmodule

/* source/mem_subsystem_top.sv */
`timescale 1ns/1ps

module mem_subsystem_top (
    input  logic clk,
    input  logic rst,
    input  logic prev_stalled,
    output logic stall_next,
    input  logic [lsu_pkg::aligned_addr_size-1:0] addr,
    output logic access_fault,
    input  logic do_load,
    output logic [lsu_pkg::xlen-1:0] load_data,
    input  logic do_store,
    input  logic [lsu_pkg::xlen-1:0] store_data,
    input  logic [lsu_pkg::xlen/8-1:0] store_mask,
    input  logic fetch_req,
    input  logic [lsu_pkg::addr_size-3:0] fetch_addr,
    output logic fetch_done,
    output logic [lsu_pkg::ilen-1:0] fetch_instr,
    output logic fetch_fault
);

    logic lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready;
    logic lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready, lsu_bvalid, lsu_bready;
    logic [lsu_pkg::addr_size-1:0] lsu_araddr, lsu_awaddr;
    logic [lsu_pkg::xlen-1:0] lsu_rdata, lsu_wdata;
    logic [lsu_pkg::xlen/8-1:0] lsu_wstrb;
    logic [1:0] lsu_rresp, lsu_bresp;

    logic fetch_arvalid, fetch_arready, fetch_rvalid, fetch_rready;
    logic [lsu_pkg::addr_size-1:0] fetch_araddr;
    logic [lsu_pkg::xlen-1:0] fetch_rdata;
    logic [1:0] fetch_rresp;

    logic mem_arvalid, mem_arready, mem_rvalid, mem_rready;
    logic mem_awvalid, mem_awready, mem_wvalid, mem_wready, mem_bvalid, mem_bready;
    logic [lsu_pkg::addr_size-1:0] mem_araddr, mem_awaddr;
    logic [lsu_pkg::xlen-1:0] mem_rdata, mem_wdata;
    logic [lsu_pkg::xlen/8-1:0] mem_wstrb;
    logic [1:0] mem_rresp, mem_bresp;

    load_store u_load_store (
        .clk(clk), .rst(rst), .prev_stalled(prev_stalled), .stall_next(stall_next),
        .addr(addr), .access_fault(access_fault), .do_load(do_load), .load_data(load_data),
        .do_store(do_store), .store_data(store_data), .store_mask(store_mask),
        .arvalid(lsu_arvalid), .arready(lsu_arready), .araddr(lsu_araddr),
        .rvalid(lsu_rvalid), .rready(lsu_rready), .rdata(lsu_rdata), .rresp(lsu_rresp),
        .awvalid(lsu_awvalid), .awready(lsu_awready), .awaddr(lsu_awaddr),
        .wvalid(lsu_wvalid), .wready(lsu_wready), .wdata(lsu_wdata), .wstrb(lsu_wstrb),
        .bvalid(lsu_bvalid), .bready(lsu_bready), .bresp(lsu_bresp)
    );

    fetch_unit u_fetch_unit (
        .clk(clk), .rst(rst), .fetch_req(fetch_req), .fetch_addr(fetch_addr),
        .fetch_done(fetch_done), .fetch_instr(fetch_instr), .fetch_fault(fetch_fault),
        .arvalid(fetch_arvalid), .arready(fetch_arready), .araddr(fetch_araddr),
        .rvalid(fetch_rvalid), .rready(fetch_rready), .rdata(fetch_rdata),
        .rresp(fetch_rresp)
    );

    bus_arbiter u_bus_arbiter (
        .clk(clk), .rst(rst),
        .lsu_arvalid, .lsu_arready, .lsu_araddr, .lsu_rvalid, .lsu_rready, .lsu_rdata,
        .lsu_rresp, .lsu_awvalid, .lsu_awready, .lsu_awaddr, .lsu_wvalid, .lsu_wready,
        .lsu_wdata, .lsu_wstrb, .lsu_bvalid, .lsu_bready, .lsu_bresp,
        .fetch_arvalid, .fetch_arready, .fetch_araddr, .fetch_rvalid, .fetch_rready,
        .fetch_rdata, .fetch_rresp,
        .mem_arvalid, .mem_arready, .mem_araddr, .mem_rvalid, .mem_rready, .mem_rdata,
        .mem_rresp, .mem_awvalid, .mem_awready, .mem_awaddr, .mem_wvalid, .mem_wready,
        .mem_wdata, .mem_wstrb, .mem_bvalid, .mem_bready, .mem_bresp
    );

    mem_bram u_mem_bram (
        .clk(clk), .rst(rst),
        .arvalid(mem_arvalid), .arready(mem_arready), .araddr(mem_araddr),
        .rvalid(mem_rvalid), .rready(mem_rready), .rdata(mem_rdata), .rresp(mem_rresp),
        .awvalid(mem_awvalid), .awready(mem_awready), .awaddr(mem_awaddr),
        .wvalid(mem_wvalid), .wready(mem_wready), .wdata(mem_wdata), .wstrb(mem_wstrb),
        .bvalid(mem_bvalid), .bready(mem_bready), .bresp(mem_bresp)
    );

endmodule

/* tests/mem_subsystem_assert.sv */
`timescale 1ns/1ps

module mem_subsystem_assert (
    input logic clk,
    input logic rst,
    input logic lsu_arvalid,
    input logic lsu_arready,
    input logic [lsu_pkg::addr_size-1:0] lsu_araddr,
    input logic lsu_rvalid,
    input logic lsu_awvalid,
    input logic lsu_awready,
    input logic [lsu_pkg::addr_size-1:0] lsu_awaddr,
    input logic lsu_wvalid,
    input logic lsu_wready,
    input logic [lsu_pkg::xlen-1:0] lsu_wdata,
    input logic [lsu_pkg::xlen/8-1:0] lsu_wstrb,
    input logic fetch_arvalid,
    input logic fetch_arready,
    input logic [lsu_pkg::addr_size-1:0] fetch_araddr,
    input logic fetch_rvalid,
    input logic mem_bvalid,
    input logic [1:0] mem_bresp
);

    // --------------------------------------------------
    // grant stays with the peer until its read response
    // --------------------------------------------------
    lsu_read_routed: assert property (@(posedge clk) disable iff (rst)
        lsu_arvalid && lsu_arready |=> lsu_rvalid)
        else $error("read response did not return to the load/store peer");

    fetch_read_routed: assert property (@(posedge clk) disable iff (rst)
        fetch_arvalid && fetch_arready |=> fetch_rvalid)
        else $error("read response did not return to the fetch peer");

    // --------------------------------------------------
    // valid and payload hold until the beat
    // --------------------------------------------------
    lsu_ar_hold: assert property (@(posedge clk) disable iff (rst)
        lsu_arvalid && !lsu_arready |=> lsu_arvalid && $stable(lsu_araddr))
        else $error("load/store ar channel dropped or changed before its beat");

    lsu_aw_hold: assert property (@(posedge clk) disable iff (rst)
        lsu_awvalid && !lsu_awready |=> lsu_awvalid && $stable(lsu_awaddr))
        else $error("load/store aw channel dropped or changed before its beat");

    lsu_w_hold: assert property (@(posedge clk) disable iff (rst)
        lsu_wvalid && !lsu_wready |=> lsu_wvalid && $stable(lsu_wdata) && $stable(lsu_wstrb))
        else $error("load/store w channel dropped or changed before its beat");

    fetch_ar_hold: assert property (@(posedge clk) disable iff (rst)
        fetch_arvalid && !fetch_arready |=> fetch_arvalid && $stable(fetch_araddr))
        else $error("fetch ar channel dropped or changed before its beat");

    write_resp_okay: assert property (@(posedge clk) disable iff (rst)
        mem_bvalid |-> mem_bresp == lsu_pkg::resp_okay)
        else $error("write response is not okay");

endmodule

/* tests/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

    localparam int clk_period = 20;
    localparam int reset_cycles = 10;
    // upper bounds on issued operations and on cycles per operation.
    localparam int num_ops = 48;
    localparam int miss_bound = 10;

    logic clk;
    logic rst;
    logic prev_stalled;
    logic stall_next;
    logic [lsu_pkg::aligned_addr_size-1:0] addr;
    logic access_fault;
    logic do_load;
    logic [lsu_pkg::xlen-1:0] load_data;
    logic do_store;
    logic [lsu_pkg::xlen-1:0] store_data;
    logic [lsu_pkg::xlen/8-1:0] store_mask;
    logic fetch_req;
    logic [lsu_pkg::addr_size-3:0] fetch_addr;
    logic fetch_done;
    logic [lsu_pkg::ilen-1:0] fetch_instr;
    logic fetch_fault;

    // reference memory, one entry per backed word.
    logic [lsu_pkg::xlen-1:0] ref_mem [lsu_pkg::mem_words];
    integer seed;

    mem_subsystem_top u_dut (
        .clk, .rst, .prev_stalled, .stall_next, .addr, .access_fault, .do_load,
        .load_data, .do_store, .store_data, .store_mask, .fetch_req, .fetch_addr,
        .fetch_done, .fetch_instr, .fetch_fault
    );

    bind bus_arbiter mem_subsystem_assert u_bus_checks (
        .clk, .rst, .lsu_arvalid, .lsu_arready, .lsu_araddr, .lsu_rvalid,
        .lsu_awvalid, .lsu_awready, .lsu_awaddr, .lsu_wvalid, .lsu_wready,
        .lsu_wdata, .lsu_wstrb, .fetch_arvalid, .fetch_arready, .fetch_araddr,
        .fetch_rvalid, .mem_bvalid, .mem_bresp
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else
            stop_on_error($sformatf("Error at %0d ns: %s = 0x%0h, expected 0x%0h",
                                    $time, name, got, exp));
    endtask

    // masked bytes replace the old ones.
    function automatic logic [lsu_pkg::xlen-1:0] merge_bytes(
        input logic [lsu_pkg::xlen-1:0] old_word,
        input logic [lsu_pkg::xlen-1:0] new_word,
        input logic [lsu_pkg::xlen/8-1:0] mask
    );
        logic [lsu_pkg::xlen-1:0] result;
        result = old_word;
        for (int i = 0; i < lsu_pkg::xlen / 8; i++) begin
            if (mask[i]) begin
                result[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return result;
    endfunction

    function automatic logic [lsu_pkg::xlen-1:0] random_word();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic [lsu_pkg::xlen/8-1:0] random_partial_mask();
        logic [lsu_pkg::xlen/8-1:0] mask;
        mask = $random(seed);
        if (mask == '0 || &mask) begin
            mask = 8'h3c;
        end
        return mask;
    endfunction

    task automatic do_load_check(input logic [lsu_pkg::aligned_addr_size-1:0] a,
                                 input int exp_cycles);
        logic exp_fault;
        int cycles;
        exp_fault = a >= lsu_pkg::mem_words;
        @(negedge clk);
        addr = a;
        do_load = 1'b1;
        prev_stalled = 1'b0;
        @(negedge clk);
        do_load = 1'b0;
        prev_stalled = 1'b1;
        cycles = 1;
        while (stall_next) begin
            @(negedge clk);
            cycles++;
        end
        check_value("access_fault", access_fault, exp_fault);
        if (!exp_fault) begin
            check_value("load_data", load_data, ref_mem[a[lsu_pkg::mem_index_bits-1:0]]);
        end
        check_value("load latency", cycles, exp_cycles);
    endtask

    task automatic do_store_op(input logic [lsu_pkg::aligned_addr_size-1:0] a,
                               input logic [lsu_pkg::xlen-1:0] d,
                               input logic [lsu_pkg::xlen/8-1:0] m);
        @(negedge clk);
        addr = a;
        store_data = d;
        store_mask = m;
        do_store = 1'b1;
        prev_stalled = 1'b0;
        @(negedge clk);
        do_store = 1'b0;
        prev_stalled = 1'b1;
        while (stall_next) begin
            @(negedge clk);
        end
        check_value("access_fault", access_fault, 1'b0);
        ref_mem[a[lsu_pkg::mem_index_bits-1:0]] =
            merge_bytes(ref_mem[a[lsu_pkg::mem_index_bits-1:0]], d, m);
    endtask

    task automatic do_fetch_check(input logic [lsu_pkg::addr_size-3:0] fa,
                                  input int exp_cycles);
        logic [lsu_pkg::aligned_addr_size-1:0] word_addr;
        logic [lsu_pkg::xlen-1:0] word;
        logic exp_fault;
        int cycles;
        word_addr = fa[lsu_pkg::addr_size-3:1];
        exp_fault = word_addr >= lsu_pkg::mem_words;
        word = exp_fault ? '0 : ref_mem[word_addr[lsu_pkg::mem_index_bits-1:0]];
        @(negedge clk);
        fetch_addr = fa;
        fetch_req = 1'b1;
        @(negedge clk);
        fetch_req = 1'b0;
        cycles = 1;
        while (!fetch_done) begin
            @(negedge clk);
            cycles++;
        end
        check_value("fetch_fault", fetch_fault, exp_fault);
        if (!exp_fault) begin
            check_value("fetch_instr", fetch_instr, fa[0] ? word[63:32] : word[31:0]);
        end
        check_value("fetch latency", cycles, exp_cycles);
    endtask

    initial begin
        #((reset_cycles + num_ops * miss_bound) * clk_period);
        stop_on_error("watchdog expired before all operations completed");
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        prev_stalled = 1'b1;
        addr = '0;
        do_load = 1'b0;
        do_store = 1'b0;
        store_data = '0;
        store_mask = '0;
        fetch_req = 1'b0;
        fetch_addr = '0;
        seed = 32'hc2e8;
        for (int i = 0; i < lsu_pkg::mem_words; i++) begin
            ref_mem[i] = '0;
        end
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("stall_next", stall_next, 1'b1);
        check_value("fetch_done", fetch_done, 1'b0);

        // --------------------------------------------------
        // loads, full and partial stores
        // --------------------------------------------------
        do_load_check(13'h010, 2);
        do_load_check(13'h010, 1);
        for (int i = 0; i < 4; i++) begin
            do_store_op(13'h020 + i, random_word(), 8'hff);
            do_load_check(13'h020 + i, 1);
        end
        // partial store over a cached word.
        do_store_op(13'h030, random_word(), 8'hff);
        do_store_op(13'h030, random_word(), random_partial_mask());
        do_load_check(13'h030, 1);
        do_store_op(13'h050, random_word(), random_partial_mask());
        do_load_check(13'h050, 2);
        // 0x071 evicts 0x061, same index.
        do_store_op(13'h061, random_word(), 8'hff);
        do_store_op(13'h071, random_word(), 8'hff);
        do_store_op(13'h061, random_word(), random_partial_mask());
        do_load_check(13'h061, 2);

        // out of range loads.
        do_load_check(13'h1000, 2);
        do_load_check(13'h1fff, 2);
        do_load_check(13'h1000, 2);

        // --------------------------------------------------
        // instruction fetch
        // --------------------------------------------------
        do_store_op(13'h080, random_word(), 8'hff);
        do_fetch_check(14'h100, 2);
        do_fetch_check(14'h101, 2);
        do_fetch_check(14'h100, 1);
        do_fetch_check(14'h101, 1);
        do_fetch_check(14'h2000, 2);
        do_fetch_check(14'h3fff, 2);
        do_fetch_check(14'h100, 1);

        // --------------------------------------------------
        // both peers in the same cycle
        // --------------------------------------------------
        do_store_op(13'h092, random_word(), 8'hff);
        do_store_op(13'h0a3, random_word(), 8'hff);
        do_store_op(13'h0b3, random_word(), 8'hff);
        fork
            do_load_check(13'h0a3, 2);
            do_fetch_check(14'h124, 4);
        join
        do_fetch_check(14'h125, 2);

        // load and store wait while the fetch peer holds the bus.
        fork
            do_fetch_check(14'h126, 2);
            begin
                @(negedge clk);
                do_load_check(13'h0b3, 3);
            end
        join
        fork
            do_fetch_check(14'h127, 2);
            begin
                @(negedge clk);
                do_store_op(13'h0c4, random_word(), 8'hff);
            end
        join
        do_load_check(13'h0c4, 1);

        $display("test passed");
        $finish;
    end

endmodule
